// File: project.f
+incdir+dv
common/line_code_pkg.sv
line_encoder/enc_5b6b.sv
line_encoder/enc_3b4b.sv
line_encoder/symbol_encoder.sv
design/enc_8b10b_tx.sv
dv/tb_enc_8b10b.sv

// File: Bender.yml
package:
  name: enc_8b10b

sources:
  - common/line_code_pkg.sv
  - line_encoder/enc_5b6b.sv
  - line_encoder/enc_3b4b.sv
  - line_encoder/symbol_encoder.sv
  - design/enc_8b10b_tx.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_enc_8b10b.sv

// File: dv/enc_8b10b_model.svh
// Standard 6b codes at negative running disparity, D.0 first
localparam logic [0:31][5:0] code6_neg = {
        6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
        6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
        6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
        6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
};

// Standard 4b codes at negative running disparity, D.x.0 first
localparam logic [0:7][3:0] code4_neg = {
        4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
};

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        // x^32 + x^22 + x^2 + x + 1
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
                state = lfsr_next(state);
                value = {value[30:0], state[0]};
        end
endtask

function automatic logic model_is_ctrl(input logic [7:0] b);
        if (b[4:0] == 5'd28) begin
                return 1'b1;
        end
        return (b[7:5] == 3'd7) && (b[4:0] == 5'd23 || b[4:0] == 5'd27
                || b[4:0] == 5'd29 || b[4:0] == 5'd30);
endfunction

// K28.1, K28.5 and K28.7 carry the comma
function automatic logic expects_comma(input logic [7:0] b, input logic k);
        return k && (b[4:0] == 5'd28) && (b[7:5] == 3'd1 || b[7:5] == 3'd5 || b[7:5] == 3'd7);
endfunction

// Twelve control bytes, K28.0 to K28.7 first
function automatic logic [7:0] control_byte(input int idx);
        case (idx)
                8:       return 8'hf7;
                9:       return 8'hfb;
                10:      return 8'hfd;
                11:      return 8'hfe;
                default: return {idx[2:0], 5'd28};
        endcase
endfunction

// Returns {new running disparity, abcdei fghj}
function automatic logic [10:0] model_encode(input logic [7:0] b, input logic k,
                                             input logic rd_in);
        logic       ctrl;
        logic       k28;
        logic       alt7;
        logic       rd_mid;
        logic       rd_out;
        logic [5:0] c6;
        logic [3:0] c4;

        ctrl = k && model_is_ctrl(b);
        k28  = ctrl && (b[4:0] == 5'd28);
        c6   = k28 ? 6'b001111 : code6_neg[b[4:0]];
        if (rd_in && ($countones(c6) != 3 || b[4:0] == 5'd7)) begin
                c6 = ~c6;
        end
        rd_mid = ($countones(c6) == 3) ? rd_in : ($countones(c6) > 3);

        alt7 = ctrl
                || (!rd_in && (b[4:0] == 5'd17 || b[4:0] == 5'd18 || b[4:0] == 5'd20))
                || (rd_in && (b[4:0] == 5'd11 || b[4:0] == 5'd13 || b[4:0] == 5'd14));
        c4 = (b[7:5] == 3'd7 && alt7) ? 4'b0111 : code4_neg[b[7:5]];
        if (rd_mid) begin
                if ($countones(c4) != 2 || b[7:5] == 3'd3) begin
                        c4 = ~c4;
                end
        end else if (k28 && $countones(c4) == 2 && b[7:5] != 3'd3) begin
                c4 = ~c4;
        end
        rd_out = ($countones(c4) == 2) ? rd_mid : ($countones(c4) > 2);
        return {rd_out, c6, c4};
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
                errors++;
                $display("CHECK FAILED %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
endtask

// File: dv/tb_enc_8b10b.sv
`timescale 1ns/1ps

module tb_enc_8b10b;
        import line_code_pkg::*;

        localparam int wait_limit = 200;

        logic        pclk;
        logic        reset;
        logic        in_valid;
        logic        in_ready;
        logic [7:0]  in_data;
        logic        in_k;
        logic        out_valid;
        logic        out_ready;
        symbol_t     out_symbol;

        int          errors;
        int          tests_passed;
        int          tests_failed;
        logic        timed_out;
        logic        stall_mode;
        logic [31:0] stim_lfsr;
        logic [31:0] stall_lfsr;
        logic [31:0] stall_bits;
        logic        stim_rd;
        logic        model_rd;
        int          run_sum;
        logic        prev_xfer;
        logic        prev_hold;
        symbol_t     held_symbol;
        logic [10:0] mon_enc;
        logic [10:0] exp_q[$];

        `include "enc_8b10b_model.svh"

        always #2 pclk = ~pclk;

        enc_8b10b_tx dut (
                .pclk       (pclk),
                .reset      (reset),
                .in_valid   (in_valid),
                .in_ready   (in_ready),
                .in_data    (in_data),
                .in_k       (in_k),
                .out_valid  (out_valid),
                .out_ready  (out_ready),
                .out_symbol (out_symbol)
        );

        // Sink back-pressure, low about one cycle in four
        always @(posedge pclk) begin
                if (stall_mode) begin
                        draw_bits(stall_lfsr, 2, stall_bits);
                        out_ready <= (stall_bits[1:0] != 2'b00);
                end else begin
                        out_ready <= 1'b1;
                end
        end

        ///////////////////////////////
        // Scoreboard
        ///////////////////////////////

        task automatic check_output();
                logic [10:0] exp;
                int          ones;
                if (exp_q.size() == 0) begin
                        errors++;
                        $display("symbol %h came out with no byte outstanding", out_symbol);
                end else begin
                        exp = exp_q.pop_front();
                        check_value("out_symbol", out_symbol, exp[9:0]);
                        if (exp[10] && out_symbol[9:3] != 7'b0011111
                                        && out_symbol[9:3] != 7'b1100000) begin
                                errors++;
                                $display("control symbol %h lacks the comma", out_symbol);
                        end
                end
                ones = $countones(out_symbol);
                run_sum += 2 * ones - 10;
                if (ones < 4 || ones > 6 || (run_sum != -1 && run_sum != 1)) begin
                        errors++;
                        $display("symbol %h has %0d ones, running sum now %0d",
                                 out_symbol, ones, run_sum);
                end
        endtask

        always @(posedge pclk) begin
                if (reset) begin
                        model_rd  = 1'b0;
                        run_sum   = -1;
                        prev_xfer = 1'b0;
                        prev_hold = 1'b0;
                        exp_q.delete();
                end else begin
                        check_value("out_valid", out_valid, prev_xfer || prev_hold);
                        check_value("in_ready", in_ready, !(prev_xfer || prev_hold) || out_ready);
                        if (prev_hold) begin
                                check_value("out_symbol held", out_symbol, held_symbol);
                        end
                        if (out_valid && out_ready) begin
                                check_output();
                        end
                        if (in_valid && in_ready) begin
                                mon_enc  = model_encode(in_data, in_k, model_rd);
                                model_rd = mon_enc[10];
                                exp_q.push_back({expects_comma(in_data, in_k), mon_enc[9:0]});
                        end
                        prev_xfer   = in_valid && in_ready;
                        prev_hold   = out_valid && !out_ready;
                        held_symbol = out_symbol;
                end
        end

        ///////////////////////////////
        // Stimulus
        ///////////////////////////////

        // Called right after a rising edge
        task automatic send_byte(input logic [7:0] b, input logic k);
                int          waited;
                logic [10:0] enc;
                if (timed_out) begin
                        return;
                end
                in_valid <= 1'b1;
                in_data  <= b;
                in_k     <= k;
                waited = 0;
                do begin
                        @(posedge pclk);
                        waited++;
                end while (!in_ready && waited < wait_limit);
                in_valid <= 1'b0;
                if (!in_ready) begin
                        timed_out = 1'b1;
                        $display("timeout: in_ready stayed low for %0d cycles", waited);
                end else begin
                        enc     = model_encode(b, k, stim_rd);
                        stim_rd = enc[10];
                end
        endtask

        task automatic finish_test(input string name, input int errs_before);
                int waited;
                stall_mode = 1'b0;
                waited = 0;
                while (!timed_out && exp_q.size() != 0 && waited < wait_limit) begin
                        @(posedge pclk);
                        waited++;
                end
                if (exp_q.size() != 0 && !timed_out) begin
                        timed_out = 1'b1;
                        $display("timeout: %0d symbols never left the encoder", exp_q.size());
                end
                if (errors == errs_before && !timed_out) begin
                        tests_passed++;
                        $display("test %s: ok", name);
                end else begin
                        tests_failed++;
                        $display("test %s: failed, %0d errors", name, errors - errs_before);
                end
        endtask

        initial begin : main
                logic [31:0] r;
                int          base;

                errors       = 0;
                tests_passed = 0;
                tests_failed = 0;
                timed_out    = 1'b0;
                stall_mode   = 1'b0;
                stim_lfsr    = 32'h9aab;
                stall_lfsr   = 32'h9aab;
                stim_rd      = 1'b0;
                pclk         = 1'b0;
                reset        = 1'b1;
                in_valid     = 1'b0;
                in_data      = 8'h00;
                in_k         = 1'b0;
                out_ready    = 1'b1;
                repeat (10) @(posedge pclk);
                reset <= 1'b0;
                @(posedge pclk);

                base = errors;
                check_value("out_valid", out_valid, 1'b0);
                check_value("in_ready", in_ready, 1'b1);
                send_byte(8'h00, 1'b0);
                @(posedge pclk);
                check_value("out_symbol", out_symbol, 10'b100111_0100);
                finish_test("reset_and_first_symbol", base);

                base = errors;
                for (int i = 0; i < 2000; i++) begin
                        draw_bits(stim_lfsr, 8, r);
                        send_byte(r[7:0], 1'b0);
                end
                finish_test("random_data", base);

                // D0.3 flips the disparity either way
                base = errors;
                for (int s = 0; s < 12; s++) begin
                        for (int t = 0; t < 2; t++) begin
                                if (stim_rd != t[0]) begin
                                        send_byte(8'h60, 1'b0);
                                end
                                send_byte(control_byte(s), 1'b1);
                        end
                end
                finish_test("control_symbols", base);

                base = errors;
                stall_mode = 1'b1;
                for (int i = 0; i < 1000; i++) begin
                        draw_bits(stim_lfsr, 12, r);
                        if (r[11:10] == 2'b00) begin
                                repeat (int'(r[9]) + 1) @(posedge pclk);
                        end
                        send_byte(r[7:0], r[8]);
                end
                finish_test("output_stalls", base);

                base = errors;
                for (int i = 0; i < 500; i++) begin
                        draw_bits(stim_lfsr, 9, r);
                        if (r[8]) begin
                                send_byte(control_byte(r[7:0] % 12), 1'b1);
                        end else begin
                                send_byte(r[7:0], 1'b0);
                        end
                end
                finish_test("disparity_bounds", base);

                base = errors;
                for (int i = 0; i < 300; i++) begin
                        draw_bits(stim_lfsr, 8, r);
                        if (!model_is_ctrl(r[7:0])) begin
                                send_byte(r[7:0], 1'b1);
                        end
                end
                finish_test("illegal_k_as_data", base);

                $display("tests passed %0d, failed %0d, errors %0d",
                         tests_passed, tests_failed, errors);
                if (errors == 0 && tests_failed == 0 && !timed_out) begin
                        $display("TB PASSED");
                end else begin
                        $display("TB FAILED");
                end
                $finish;
        end

endmodule

// File: design/enc_8b10b_tx.sv
`timescale 1ns/1ps

module enc_8b10b_tx (
        input  logic                      pclk,
        input  logic                      reset,
        input  logic                      in_valid,
        output logic                      in_ready,
        input  line_code_pkg::data_byte_u in_data,
        input  logic                      in_k,
        output logic                      out_valid,
        input  logic                      out_ready,
        output line_code_pkg::symbol_t    out_symbol
);
        import line_code_pkg::*;

        logic    rd;
        logic    rd_next;
        logic    in_xfer;
        symbol_t enc_symbol;

        ///////////////////////////////
        // Handshake
        ///////////////////////////////

        // Accept when the output slot is empty or draining this cycle
        assign in_ready = !out_valid || out_ready;
        assign in_xfer  = in_valid && in_ready;

        ///////////////////////////////
        // Encoder
        ///////////////////////////////

        symbol_encoder u_symbol_encoder (
                .data   (in_data),
                .k      (in_k),
                .rd_in  (rd),
                .symbol (enc_symbol),
                .rd_out (rd_next)
        );

        ///////////////////////////////
        // State
        ///////////////////////////////

        // Running disparity, 0 is negative
        always_ff @(posedge pclk) begin
                if (reset) begin
                        rd <= 1'b0;
                end else if (in_xfer) begin
                        rd <= rd_next;
                end
        end

        always_ff @(posedge pclk) begin
                if (reset) begin
                        out_valid <= 1'b0;
                end else if (in_xfer) begin
                        out_valid <= 1'b1;
                end else if (out_ready) begin
                        out_valid <= 1'b0;
                end
        end

        // Holds under back-pressure
        always_ff @(posedge pclk) begin
                if (in_xfer) begin
                        out_symbol <= enc_symbol;
                end
        end

endmodule

// File: line_encoder/symbol_encoder.sv
`timescale 1ns/1ps

module symbol_encoder (
        input  line_code_pkg::data_byte_u data,
        input  logic                      k,
        input  logic                      rd_in,
        output line_code_pkg::symbol_t    symbol,
        output logic                      rd_out
);
        import line_code_pkg::*;

        logic   ctrl;
        logic   k_x7_hit;
        logic   unb6;
        logic   unb4;
        logic   rd_mid;
        code6_t code6;
        code4_t code4;

        ///////////////////////////////
        // Control classification
        ///////////////////////////////

        always_comb begin
                k_x7_hit = 1'b0;
                for (int i = 0; i < 4; i++) begin
                        if (data.raw == {3'd7, k_x7_set[i]}) begin
                                k_x7_hit = 1'b1;
                        end
                end
        end

        // Any other k byte goes out as plain data
        assign ctrl = k && (k_x7_hit || data.sub.edcba == k28_edcba);

        ///////////////////////////////
        // Sub-blocks
        ///////////////////////////////

        enc_5b6b u_enc_5b6b (
                .edcba      (data.sub.edcba),
                .ctrl       (ctrl),
                .rd         (rd_in),
                .code       (code6),
                .unbalanced (unb6)
        );

        assign rd_mid = rd_in ^ unb6;

        enc_3b4b u_enc_3b4b (
                .hgf        (data.sub.hgf),
                .edcba      (data.sub.edcba),
                .ctrl       (ctrl),
                .rd         (rd_mid),
                .code       (code4),
                .unbalanced (unb4)
        );

        assign rd_out = rd_mid ^ unb4;
        assign symbol = {code6, code4};

endmodule

// File: line_encoder/enc_3b4b.sv
`timescale 1ns/1ps

module enc_3b4b (
        input  logic [2:0]            hgf,
        input  logic [4:0]            edcba,
        input  logic                  ctrl,
        input  logic                  rd,
        output line_code_pkg::code4_t code,
        output logic                  unbalanced
);
        import line_code_pkg::*;

        code4_t neg_code;
        logic   use_alt7;
        logic   is_k28;

        assign is_k28 = ctrl && (edcba == k28_edcba);

        // Alternate 7 avoids a run of five ones or zeros across e/i and f/g
        assign use_alt7 = ctrl
                || (!rd && (edcba == 5'd17 || edcba == 5'd18 || edcba == 5'd20))
                || (rd && (edcba == 5'd11 || edcba == 5'd13 || edcba == 5'd14));

        always_comb begin
                case (hgf)
                        3'd0:    neg_code = 4'b1011;
                        3'd1:    neg_code = 4'b1001;
                        3'd2:    neg_code = 4'b0101;
                        3'd3:    neg_code = 4'b1100;
                        3'd4:    neg_code = 4'b1101;
                        3'd5:    neg_code = 4'b1010;
                        3'd6:    neg_code = 4'b0110;
                        default: neg_code = use_alt7 ? 4'b0111 : 4'b1110;
                endcase
        end

        assign unbalanced = ($countones(neg_code) != 2);

        ///////////////////////////////
        // Disparity selection
        ///////////////////////////////

        // rd here is the disparity after the 6b code
        always_comb begin
                code = neg_code;
                if (rd && (unbalanced || hgf == 3'd3)) begin
                        code = ~neg_code;
                end else if (is_k28 && !rd && !unbalanced && hgf != 3'd3) begin
                        // K28.1/.2/.5/.6 after 110000
                        code = ~neg_code;
                end
        end

endmodule

// File: line_encoder/enc_5b6b.sv
`timescale 1ns/1ps

module enc_5b6b (
        input  logic [4:0]            edcba,
        input  logic                  ctrl,
        input  logic                  rd,
        output line_code_pkg::code6_t code,
        output logic                  unbalanced
);
        import line_code_pkg::*;

        code6_t neg_code;
        logic   is_k28;

        assign is_k28 = ctrl && (edcba == k28_edcba);

        ///////////////////////////////
        // Negative disparity column
        ///////////////////////////////

        always_comb begin
                case (edcba)
                        5'd0:    neg_code = 6'b100111;
                        5'd1:    neg_code = 6'b011101;
                        5'd2:    neg_code = 6'b101101;
                        5'd3:    neg_code = 6'b110001;
                        5'd4:    neg_code = 6'b110101;
                        5'd5:    neg_code = 6'b101001;
                        5'd6:    neg_code = 6'b011001;
                        5'd7:    neg_code = 6'b111000;
                        5'd8:    neg_code = 6'b111001;
                        5'd9:    neg_code = 6'b100101;
                        5'd10:   neg_code = 6'b010101;
                        5'd11:   neg_code = 6'b110100;
                        5'd12:   neg_code = 6'b001101;
                        5'd13:   neg_code = 6'b101100;
                        5'd14:   neg_code = 6'b011100;
                        5'd15:   neg_code = 6'b010111;
                        5'd16:   neg_code = 6'b011011;
                        5'd17:   neg_code = 6'b100011;
                        5'd18:   neg_code = 6'b010011;
                        5'd19:   neg_code = 6'b110010;
                        5'd20:   neg_code = 6'b001011;
                        5'd21:   neg_code = 6'b101010;
                        5'd22:   neg_code = 6'b011010;
                        5'd23:   neg_code = 6'b111010;
                        5'd24:   neg_code = 6'b110011;
                        5'd25:   neg_code = 6'b100110;
                        5'd26:   neg_code = 6'b010110;
                        5'd27:   neg_code = 6'b110110;
                        5'd28:   neg_code = 6'b001110;
                        5'd29:   neg_code = 6'b101110;
                        5'd30:   neg_code = 6'b011110;
                        default: neg_code = 6'b101011;
                endcase

                // K28 replaces the data entry
                if (is_k28) begin
                        neg_code = 6'b001111;
                end
        end

        ///////////////////////////////
        // Disparity selection
        ///////////////////////////////

        assign unbalanced = ($countones(neg_code) != 3);

        // D.07 is balanced but still swaps to 000111 at positive disparity
        always_comb begin
                code = neg_code;
                if (rd && (unbalanced || edcba == 5'd7)) begin
                        code = ~neg_code;
                end
        end

endmodule

// File: common/line_code_pkg.sv
package line_code_pkg;

        ///////////////////////////////
        // Widths
        ///////////////////////////////

        localparam int byte_w   = 8;
        localparam int symbol_w = 10;

        ///////////////////////////////
        // Code types
        ///////////////////////////////

        // abcdei
        typedef logic [5:0] code6_t;

        // fghj
        typedef logic [3:0] code4_t;

        // abcdei in the high bits, fghj in the low bits
        typedef logic [symbol_w-1:0] symbol_t;

        typedef struct packed {
                logic [2:0] hgf;
                logic [4:0] edcba;
        } byte_fields_t;

        // Same byte, seen whole or split into the two sub-blocks
        typedef union packed {
                logic [byte_w-1:0] raw;
                byte_fields_t      sub;
        } data_byte_u;

        ///////////////////////////////
        // Control symbols
        ///////////////////////////////

        localparam logic [4:0] k28_edcba = 5'd28;

        // EDCBA values allowed with HGF 7 (K23.7, K27.7, K29.7, K30.7)
        localparam logic [3:0][4:0] k_x7_set = {5'd30, 5'd29, 5'd27, 5'd23};

endpackage
